/* project.f */
+incdir+src
src/gnn_pkg.sv
src/rr_arbiter.sv
src/req_fifo.sv
src/bus_arbiter.sv
src/mem_cntl.sv
src/gnn_mem_subsys.sv
verification/tb_gnn_mem_subsys.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the GNN memory bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f project.f \
    --top-module tb_gnn_mem_subsys

# a failing run exits nonzero, keep its output for the search below
output=$(./obj_dir/Vtb_gnn_mem_subsys 2>&1) || true
echo "$output"

if echo "$output" | grep -qxF '** PASS **'; then
    exit 0
else
    exit 1
fi

/* src/bus_arbiter.sv */
`include "gnn_macros.svh"

module bus_arbiter import gnn_pkg::*; (
    input  logic                              clk,
    input  logic                              reset,
    input  req_bus_t [`NUM_EDGE_PE-1:0]       req_in,
    input  logic                              fv_almost_full,
    input  logic                              nb_almost_full,
    output logic     [`NUM_EDGE_PE-1:0]       grant,
    output mem_req_t                          fv_req,
    output mem_req_t                          nb_req
);

    // one sampled request slot per PE
    req_bus_t [`NUM_EDGE_PE-1:0] slot_q;
    // slot requests after queue back-pressure
    logic     [`NUM_EDGE_PE-1:0] slot_req;
    logic     [`NUM_EDGE_PE-1:0] slot_blocked;
    // granted slot contents or zero when nobody wins
    req_bus_t                    winner;

    // the edge closing a grant still sees the PE's req
    // so the granted slot is cleared instead of reloaded
    always_ff @(posedge clk) begin
        if (reset) begin
            slot_q <= '0;
        end else begin
            for (int i = 0; i < `NUM_EDGE_PE; i++) begin
                slot_q[i]     <= req_in[i];
                slot_q[i].req <= req_in[i].req & ~grant[i];
            end
        end
    end

    // hold back requests whose target queue is nearly full
    always_comb begin
        for (int i = 0; i < `NUM_EDGE_PE; i++) begin
            if (slot_q[i].req_type == REQ_TYPE_FV) begin
                slot_blocked[i] = fv_almost_full;
            end else begin
                slot_blocked[i] = nb_almost_full;
            end
            slot_req[i] = slot_q[i].req & ~slot_blocked[i];
        end
    end

    rr_arbiter #(
        .num_reqs(`NUM_EDGE_PE)
    ) rr_arbiter_i (
        .clk(clk),
        .reset(reset),
        .reqs(slot_req),
        .grants(grant)
    );

    // pick the granted slot
    always_comb begin
        winner = '0;
        for (int i = 0; i < `NUM_EDGE_PE; i++) begin
            if (grant[i]) begin
                winner = slot_q[i];
            end
        end
    end

    // route the winner by type one cycle after the grant
    always_ff @(posedge clk) begin
        if (reset) begin
            fv_req.valid <= 1'b0;
            nb_req.valid <= 1'b0;
        end else begin
            fv_req.valid   <= winner.req && (winner.req_type == REQ_TYPE_FV);
            nb_req.valid   <= winner.req && (winner.req_type == REQ_TYPE_NB);
            // payload goes to both outputs and only one is valid
            fv_req.node_id <= winner.node_id;
            fv_req.pe_tag  <= winner.pe_tag;
            nb_req.node_id <= winner.node_id;
            nb_req.pe_tag  <= winner.pe_tag;
        end
    end

    // a routed request never targets both controllers
    route_exclusive_a: assert property (
        @(posedge clk) disable iff (reset)
        !(fv_req.valid && nb_req.valid)
    ) else $error("bus_arbiter: request routed to both controllers");

endmodule

/* src/gnn_macros.svh */
`ifndef GNN_MACROS_SVH
`define GNN_MACROS_SVH

// edge PEs sharing the memory bus
`define NUM_EDGE_PE 4

// node id width, also sets memory depth per controller
`define NODE_ID_W 8

// enough tag bits to name every PE
`define PE_TAG_W 2

// feature vector word
`define FV_DATA_W 32

// neighbor list pointer
`define NB_DATA_W 16

// request queue entries per controller
`define REQ_Q_DEPTH 4

`endif

/* src/gnn_mem_subsys.sv */
`include "gnn_macros.svh"

module gnn_mem_subsys import gnn_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  req_bus_t [`NUM_EDGE_PE-1:0] req_in,
    input  mem_load_t                   load,
    output logic     [`NUM_EDGE_PE-1:0] grant,
    output fv_rsp_t                     fv_rsp,
    output nb_rsp_t                     nb_rsp
);

    // routed requests, arbiter to controllers
    mem_req_t fv_req;
    mem_req_t nb_req;
    // queue back-pressure, controllers to arbiter
    logic     fv_almost_full;
    logic     nb_almost_full;

    bus_arbiter bus_arbiter_i (
        .clk(clk),
        .reset(reset),
        .req_in(req_in),
        .fv_almost_full(fv_almost_full),
        .nb_almost_full(nb_almost_full),
        .grant(grant),
        .fv_req(fv_req),
        .nb_req(nb_req)
    );

    // feature vector memory, full word
    mem_cntl #(
        .data_w(`FV_DATA_W),
        .mem_sel(SEL_FV),
        .rsp_t(fv_rsp_t)
    ) fv_cntl_i (
        .clk(clk),
        .reset(reset),
        .req(fv_req),
        .load(load),
        .rsp(fv_rsp),
        .almost_full(fv_almost_full)
    );

    // neighbor list memory, narrow pointers
    mem_cntl #(
        .data_w(`NB_DATA_W),
        .mem_sel(SEL_NB),
        .rsp_t(nb_rsp_t)
    ) nb_cntl_i (
        .clk(clk),
        .reset(reset),
        .req(nb_req),
        .load(load),
        .rsp(nb_rsp),
        .almost_full(nb_almost_full)
    );

endmodule

/* src/gnn_pkg.sv */
`include "gnn_macros.svh"

package gnn_pkg;

    // req_type encodings
    localparam logic REQ_TYPE_NB = 1'b0;
    localparam logic REQ_TYPE_FV = 1'b1;

    // load port memory select
    localparam logic SEL_NB = 1'b0;
    localparam logic SEL_FV = 1'b1;

    // one PE's bus request, held until granted
    typedef struct packed {
        logic                  req;
        logic                  req_type;
        logic [`NODE_ID_W-1:0] node_id;
        logic [`PE_TAG_W-1:0]  pe_tag;
    } req_bus_t;

    // routed request into a controller queue
    typedef struct packed {
        logic                  valid;
        logic [`NODE_ID_W-1:0] node_id;
        logic [`PE_TAG_W-1:0]  pe_tag;
    } mem_req_t;

    // feature memory read response
    typedef struct packed {
        logic                  valid;
        logic [`PE_TAG_W-1:0]  pe_tag;
        logic [`FV_DATA_W-1:0] data;
    } fv_rsp_t;

    // neighbor memory read response
    typedef struct packed {
        logic                  valid;
        logic [`PE_TAG_W-1:0]  pe_tag;
        logic [`NB_DATA_W-1:0] data;
    } nb_rsp_t;

    // load port write, neighbor memory keeps the low data bits
    typedef struct packed {
        logic                  wr_en;
        logic                  sel;
        logic [`NODE_ID_W-1:0] addr;
        logic [`FV_DATA_W-1:0] data;
    } mem_load_t;

endpackage

/* src/mem_cntl.sv */
`include "gnn_macros.svh"

module mem_cntl import gnn_pkg::*; #(
    parameter int   data_w  = `FV_DATA_W,
    parameter logic mem_sel = SEL_FV,
    parameter type  rsp_t   = fv_rsp_t
) (
    input  logic      clk,
    input  logic      reset,
    input  mem_req_t  req,
    input  mem_load_t load,
    output rsp_t      rsp,
    output logic      almost_full
);

    localparam int mem_words = 2 ** `NODE_ID_W;

    // single port array, one access per cycle
    logic [data_w-1:0]    mem [mem_words];

    // queue head and control
    mem_req_t             head;
    logic                 q_empty;
    logic                 wr_hit;
    logic                 pop;

    // response registers
    logic                 rsp_valid_q;
    logic [`PE_TAG_W-1:0] rsp_tag_q;
    logic [data_w-1:0]    rsp_data_q;

    req_fifo #(
        .payload_t(mem_req_t),
        .depth(`REQ_Q_DEPTH)
    ) req_q_i (
        .clk(clk),
        .reset(reset),
        .push(req.valid),
        .push_data(req),
        .pop(pop),
        .pop_data(head),
        .empty(q_empty),
        .almost_full(almost_full)
    );

    // load write for this memory owns the port this cycle
    assign wr_hit = load.wr_en && (load.sel == mem_sel);
    // otherwise serve the oldest queued request
    assign pop    = !q_empty && !wr_hit;

    // narrow memory keeps the low data bits
    always_ff @(posedge clk) begin
        if (wr_hit) begin
            mem[load.addr] <= load.data[data_w-1:0];
        end
    end

    // synchronous read, tag travels alongside
    always_ff @(posedge clk) begin
        if (pop) begin
            rsp_data_q <= mem[head.node_id];
            rsp_tag_q  <= head.pe_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= pop;
        end
    end

    // pack response, same fields for both widths
    always_comb begin
        rsp        = '0;
        rsp.valid  = rsp_valid_q;
        rsp.pe_tag = rsp_tag_q;
        rsp.data   = rsp_data_q;
    end

endmodule

/* src/req_fifo.sv */
module req_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     almost_full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    // storage, no reset needed on entries
    payload_t         entry_q [depth];
    logic [ptr_w-1:0] wr_ptr_q;
    logic [ptr_w-1:0] rd_ptr_q;
    logic [cnt_w-1:0] count_q;
    logic             full;

    // wrap works for any depth, not only powers of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full        = (count_q == cnt_w'(depth));
    assign empty       = (count_q == '0);
    // fewer than two free entries left
    assign almost_full = (count_q >= cnt_w'(depth - 1));
    // head entry shown directly
    assign pop_data    = entry_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (push) begin
            entry_q[wr_ptr_q] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
            if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
            // simultaneous push and pop leaves count alone
            if (push && !pop) count_q <= count_q + 1'b1;
            else if (pop && !push) count_q <= count_q - 1'b1;
        end
    end

    no_push_full_a: assert property (
        @(posedge clk) disable iff (reset) !(push && full)
    ) else $error("req_fifo: push while full");

    no_pop_empty_a: assert property (
        @(posedge clk) disable iff (reset) !(pop && empty)
    ) else $error("req_fifo: pop while empty");

endmodule

/* src/rr_arbiter.sv */
module rr_arbiter #(
    parameter int num_reqs = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [num_reqs-1:0] reqs,
    output logic [num_reqs-1:0] grants
);

    // pointer needs at least one bit even for a single requester
    localparam int ptr_w = (num_reqs > 1) ? $clog2(num_reqs) : 1;

    // highest priority position for the current cycle
    logic [ptr_w-1:0] ptr_q;
    logic [ptr_w-1:0] win_idx;
    logic             win_found;

    // search from ptr upward, wrapping past the top
    always_comb begin
        int idx;
        grants    = '0;
        win_idx   = '0;
        win_found = 1'b0;
        for (int k = 0; k < num_reqs; k++) begin
            idx = (int'(ptr_q) + k) % num_reqs;
            // first hit wins, later hits ignored
            if (!win_found && reqs[idx]) begin
                win_found    = 1'b1;
                win_idx      = ptr_w'(idx);
                grants[idx]  = 1'b1;
            end
        end
    end

    // pointer moves past the winner, holds when idle
    always_ff @(posedge clk) begin
        if (reset) begin
            ptr_q <= '0;
        end else if (win_found) begin
            if (win_idx == ptr_w'(num_reqs - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= win_idx + 1'b1;
            end
        end
    end

    // at most one grant and only to a live request
    grant_onehot_subset_a: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(grants) && ((grants & ~reqs) == '0)
    ) else $error("rr_arbiter: grant not one-hot or not requested");

endmodule

/* verification/gnn_stim.txt */
# L sel addr data | R pe_mask then type node for pe0..pe3 | G count then pe order
# I idle cycles | X random request count | every field is hex
L 1 00 a0a0f000
L 1 01 a1b2c3d4
L 1 02 00ff00ff
L 1 03 13572468
L 1 04 fedcba98
L 1 05 0badc0de
L 1 06 55aa55aa
L 1 07 80000001
L 0 00 dead0010
L 0 01 beef0021
L 0 02 cafe0032
L 0 03 f00d0043
L 0 04 12340054
L 0 05 abcd0065
L 0 06 77770076
L 0 07 ffff0087
R 2 0 0 1 3 0 0 0 0
G 1 1
R 4 0 0 0 0 0 5 0 0
G 1 2
R f 1 0 0 1 1 2 0 3
G 4 3 0 1 2
R 1 0 4 0 0 0 0 0 0
G 1 0
R f 0 4 1 5 0 6 1 7
G 4 1 2 3 0
R f 1 7 1 6 0 5 0 4
G 4 1 2 3 0
I 8
R f 1 0 1 1 1 2 1 3
L 1 80 00000080
L 1 81 00000081
L 1 82 00000082
L 1 83 00000083
L 1 84 00000084
R 3 1 4 1 5 0 0 0 0
L 1 85 00000085
L 1 86 00000086
R c 0 0 0 0 0 6 0 7
L 1 87 00000087
L 1 88 00000088
L 1 89 00000089
L 1 8a 0000008a
L 1 8b 0000008b
G 8 1 2 3 0 2 3 0 1
I 6
X 3c
I 4

/* verification/tb_gnn_mem_subsys.sv */
`include "gnn_macros.svh"

module tb_gnn_mem_subsys import gnn_pkg::*; ();

    localparam int tag_w = `PE_TAG_W;
    // watchdog budget per stim record or random request
    localparam int cycles_per_item = 40;

    // one parsed stim line
    typedef struct packed {
        logic [7:0]        kind;
        logic [11:0][31:0] arg;
    } stim_rec_t;

    logic                        clk;
    logic                        reset;
    req_bus_t [`NUM_EDGE_PE-1:0] req_in;
    mem_load_t                   load;
    logic     [`NUM_EDGE_PE-1:0] grant;
    fv_rsp_t                     fv_rsp;
    nb_rsp_t                     nb_rsp;

    // PE models, request held until granted
    logic [`NUM_EDGE_PE-1:0] pend;
    logic [`NUM_EDGE_PE-1:0] ptype;
    logic [`NODE_ID_W-1:0]   pnode [`NUM_EDGE_PE];
    // memory models keep the whole load word
    logic [`FV_DATA_W-1:0]   fv_model [2**`NODE_ID_W];
    logic [`FV_DATA_W-1:0]   nb_model [2**`NODE_ID_W];
    // expected responses in grant order, per controller
    fv_rsp_t                 fv_q [$];
    nb_rsp_t                 nb_q [$];
    int                      grant_log [$];
    stim_rec_t               recs [$];
    int                      random_total;
    int                      watchdog_cycles;
    logic [31:0]             lcg_state;

    gnn_mem_subsys dut_i (
        .clk(clk),
        .reset(reset),
        .req_in(req_in),
        .load(load),
        .grant(grant),
        .fv_rsp(fv_rsp),
        .nb_rsp(nb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_fail;
        $display("** FAIL **");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic abort_run(input string reason);
        $display("Error at time %0t: %s", $time, reason);
        stop_with_fail();
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s actual %0h expected %0h",
                     $time, name, actual, expected);
            stop_with_fail();
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_reset_state;
        check_value("grant", 64'(grant), 64'd0);
        check_value("fv_rsp.valid", 64'(fv_rsp.valid), 64'd0);
        check_value("nb_rsp.valid", 64'(nb_rsp.valid), 64'd0);
    endtask

    // load write and PE request levels for one cycle
    task automatic drive_inputs(input mem_load_t ld);
        load = ld;
        if (ld.wr_en && ld.sel == SEL_FV) fv_model[ld.addr] = ld.data;
        if (ld.wr_en && ld.sel == SEL_NB) nb_model[ld.addr] = ld.data;
        for (int i = 0; i < `NUM_EDGE_PE; i++) begin
            req_in[i].req      = pend[i];
            req_in[i].req_type = ptype[i];
            req_in[i].node_id  = pnode[i];
            req_in[i].pe_tag   = tag_w'(i);
        end
    endtask

    // mid-cycle, grant and responses are settled
    task automatic sample_outputs;
        fv_rsp_t fv_exp;
        nb_rsp_t nb_exp;
        check_value("grant one-hot", 64'($onehot0(grant)), 64'd1);
        for (int i = 0; i < `NUM_EDGE_PE; i++) begin
            if (grant[i]) begin
                if (!pend[i]) abort_run($sformatf("grant to PE %0d without a request", i));
                // expected data comes from the model at grant time
                if (ptype[i] == REQ_TYPE_FV) begin
                    fv_exp.valid  = 1'b1;
                    fv_exp.pe_tag = tag_w'(i);
                    fv_exp.data   = fv_model[pnode[i]];
                    fv_q.push_back(fv_exp);
                end else begin
                    nb_exp.valid  = 1'b1;
                    nb_exp.pe_tag = tag_w'(i);
                    nb_exp.data   = nb_model[pnode[i]][`NB_DATA_W-1:0];
                    nb_q.push_back(nb_exp);
                end
                grant_log.push_back(i);
                pend[i] = 1'b0;
            end
        end
        if (fv_rsp.valid) begin
            if (fv_q.size() == 0) abort_run("feature response with nothing outstanding");
            fv_exp = fv_q.pop_front();
            check_value("fv_rsp.pe_tag", 64'(fv_rsp.pe_tag), 64'(fv_exp.pe_tag));
            check_value("fv_rsp.data", 64'(fv_rsp.data), 64'(fv_exp.data));
        end
        if (nb_rsp.valid) begin
            if (nb_q.size() == 0) abort_run("neighbor response with nothing outstanding");
            nb_exp = nb_q.pop_front();
            check_value("nb_rsp.pe_tag", 64'(nb_rsp.pe_tag), 64'(nb_exp.pe_tag));
            check_value("nb_rsp.data", 64'(nb_rsp.data), 64'(nb_exp.data));
        end
    endtask

    task automatic run_cycle(input mem_load_t ld);
        @(posedge clk);
        #10;
        drive_inputs(ld);
        @(negedge clk);
        sample_outputs();
    endtask

    task automatic read_stim;
        int               fd;
        int               code;
        int               nargs;
        logic [7:0]       kind;
        logic [31:0]      v;
        logic [8*160-1:0] skip;
        stim_rec_t        rec;
        fd = $fopen("verification/gnn_stim.txt", "r");
        if (fd == 0) abort_run("cannot open verification/gnn_stim.txt");
        while ($fscanf(fd, " %c", kind) == 1) begin
            if (kind == "#") begin
                code = $fgets(skip, fd);
            end else begin
                rec      = '0;
                rec.kind = kind;
                // load has 3 fields, burst has mask plus four type and node pairs
                nargs = (kind == "L") ? 3 : ((kind == "R") ? 9 : 1);
                // grant order lists its PEs after the count
                for (int k = 0; k < nargs; k++) begin
                    code = $fscanf(fd, "%h", v);
                    if (code != 1) abort_run("malformed line in stimulus file");
                    rec.arg[k] = v;
                    if (kind == "G" && k == 0) nargs = int'(v) + 1;
                end
                if (kind == "X") random_total += int'(rec.arg[0]);
                recs.push_back(rec);
            end
        end
        $fclose(fd);
    endtask

    // mixed LCG traffic over the loaded nodes 0 to 7
    task automatic random_traffic(input int count);
        int          issued;
        logic [31:0] r;
        logic [1:0]  pe;
        issued = 0;
        while (issued < count) begin
            r  = lcg_next();
            pe = r[17:16];
            if (!pend[pe]) begin
                pend[pe]  = 1'b1;
                ptype[pe] = r[20];
                pnode[pe] = `NODE_ID_W'(r[26:24]);
                issued++;
            end
            if (r[29] || pend == '1) run_cycle('0);
        end
    endtask

    task automatic execute_rec(input stim_rec_t rec);
        mem_load_t               ld;
        logic [`NUM_EDGE_PE-1:0] mask;
        int                      k;
        ld = '0;
        case (rec.kind)
            "L": begin
                ld.wr_en = 1'b1;
                ld.sel   = rec.arg[0][0];
                ld.addr  = rec.arg[1][`NODE_ID_W-1:0];
                ld.data  = rec.arg[2];
                run_cycle(ld);
            end
            "R": begin
                mask = rec.arg[0][`NUM_EDGE_PE-1:0];
                // a burst reuses a PE only once its last request was granted
                while ((pend & mask) != '0) run_cycle(ld);
                for (int i = 0; i < `NUM_EDGE_PE; i++) begin
                    if (mask[i]) begin
                        pend[i]  = 1'b1;
                        ptype[i] = rec.arg[2*i+1][0];
                        pnode[i] = rec.arg[2*i+2][`NODE_ID_W-1:0];
                    end
                end
            end
            "I": repeat (rec.arg[0]) run_cycle(ld);
            "X": random_traffic(int'(rec.arg[0]));
            "G": begin
                while (pend != '0) run_cycle(ld);
                k = int'(rec.arg[0]);
                if (grant_log.size() < k) abort_run("fewer grants than the expected order");
                // most recent k grants against the listed order
                for (int j = 0; j < k; j++) begin
                    check_value("grant order", 64'(grant_log[grant_log.size() - k + j]),
                                64'(rec.arg[j + 1]));
                end
                grant_log.delete();
            end
            default: abort_run("unknown line kind in stimulus file");
        endcase
    endtask

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: run did not end within %0d cycles", watchdog_cycles);
        stop_with_fail();
    end

    initial begin
        reset           = 1'b1;
        req_in          = '0;
        load            = '0;
        pend            = '0;
        ptype           = '0;
        lcg_state       = 32'hdfd1;
        random_total    = 0;
        watchdog_cycles = 0;
        for (int i = 0; i < `NUM_EDGE_PE; i++) pnode[i] = '0;
        read_stim();
        watchdog_cycles = (recs.size() + random_total) * cycles_per_item + 100;
        // 3 edges in reset, last check lands right after release
        for (int c = 0; c < 3; c++) begin
            @(posedge clk);
            #10;
            if (c == 2) reset = 1'b0;
            @(negedge clk);
            check_reset_state();
        end
        foreach (recs[n]) execute_rec(recs[n]);
        // drain, then a few quiet cycles for stray responses
        while (pend != '0 || fv_q.size() != 0 || nb_q.size() != 0) run_cycle('0);
        repeat (5) run_cycle('0);
        if (pend == '0 && fv_q.size() == 0 && nb_q.size() == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            abort_run("requests still outstanding at end of run");
        end
    end

endmodule
